// File: tlp_cases.txt
# kind 0 rx, 2 rx before id_valid: kind hdr0 hdr1 hdr2 dw3 dw4 req write daddr wdata urcpl cpl_dw1 cpl_dw2 urp urnp
# kind 1 mem response: kind req_id tag lower_addr rdata 0 dw0 dw1 dw2 data_dword empty 0 0 0 0
0 40000001 0012050F ABCD1230 11111111 DEADBEEF 1 1 48C DEADBEEF 0 0 0 0 0
0 40000001 0034070F 00005674 CAFEF00D 22222222 1 1 159D CAFEF00D 0 0 0 0 0
0 00000001 0056090F 77770008 0 0 1 0 2 0 0 0 0 0 0
0 00000002 00780AFF 00001044 0 0 0 0 0 0 1 01002008 00780A44 0 1
0 00000001 00790B03 00000010 0 0 0 0 0 0 1 01002002 00790B10 0 1
0 60000001 009A0C0F 00000000 00002000 33333333 0 0 0 0 0 0 0 1 0
2 40000001 00BC0D0F 00000100 44444444 55555555 0 0 0 0 0 0 0 0 0
1 0056 09 02 13572468 0 4A000001 01000004 00560908 4 3 0 0 0 0
1 0011 22 05 89ABCDEF 0 4A000001 01000004 00112214 3 4 0 0 0 0

// File: vlog.f
tlp_pkg.sv
tlp_byte_count.sv
tlp_rx_decoder.sv
tlp_rx_dispatch.sv
read_cpl_sender.sv
pcie_tlp_handler.sv
tb_pcie_tlp_handler.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f vlog.f --top-module tb_pcie_tlp_handler -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb_pcie_tlp_handler.sv
// Testbench for the PCIe TLP handler
// Reads one case per line from tlp_cases.txt, drives receive beats
// or memory responses, and checks requests, completions and
// UR error pulses against the expected columns of each case
`timescale 1ns/1ps

module tb_pcie_tlp_handler import tlp_pkg::*; ();

  localparam logic [15:0] COMPLETER = 16'h0100;   // Fixed completer ID
  localparam int WINDOW = 8;                       // Cycles watched per case

  logic        clk;
  logic        reset;
  st_beat_t    rx;
  logic        rx_ready;
  logic [15:0] completer_id;
  logic        id_valid;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  mem_resp_t   mem_resp;
  logic        mem_resp_valid;
  logic        mem_resp_ready;
  st_beat_t    cpl_instant;
  st_beat_t    cpl_response;
  logic        ur_posted;
  logic        ur_nonposted;

  int checks;
  int errors;

  // First cycle each event was seen, 0 when absent
  int       req_cyc;
  int       ur_cpl_cyc;
  int       rsp_cyc;
  int       urp_cyc;
  int       urnp_cyc;
  mem_req_t seen_req;
  st_beat_t seen_ur_cpl;
  st_beat_t seen_rsp;

  pcie_tlp_handler #(
    .REGION_BITS (16)
  ) i_dut (
    .clk            (clk),
    .reset          (reset),
    .rx             (rx),
    .rx_ready       (rx_ready),
    .completer_id   (completer_id),
    .id_valid       (id_valid),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_resp       (mem_resp),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .cpl_instant    (cpl_instant),
    .cpl_response   (cpl_response),
    .ur_posted      (ur_posted),
    .ur_nonposted   (ur_nonposted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns period
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  // Watch outputs at falling edges, clear stimulus after first cycle
  task automatic watch_outputs();
    req_cyc    = 0;
    ur_cpl_cyc = 0;
    rsp_cyc    = 0;
    urp_cyc    = 0;
    urnp_cyc   = 0;
    for (int cyc = 1; cyc <= WINDOW; cyc++) begin
      @(negedge clk);
      if (cyc == 1) begin
        rx.valid       = 1'b0;
        mem_resp_valid = 1'b0;
      end
      if (mem_req_valid) begin
        if (req_cyc != 0) report("memory request held or repeated");
        req_cyc  = cyc;
        seen_req = mem_req;
      end
      if (cpl_instant.valid) begin
        if (ur_cpl_cyc != 0) report("instant completion held or repeated");
        ur_cpl_cyc  = cyc;
        seen_ur_cpl = cpl_instant;
      end
      if (cpl_response.valid) begin
        if (rsp_cyc != 0) report("response completion held or repeated");
        rsp_cyc  = cyc;
        seen_rsp = cpl_response;
      end
      if (ur_posted && urp_cyc == 0) urp_cyc = cyc;
      if (ur_nonposted && urnp_cyc == 0) urnp_cyc = cyc;
    end
  endtask

  task automatic run_rx_case(input logic [31:0] f[15], input bit before_id);
    if (before_id) id_valid = 1'b0;
    @(negedge clk);
    // Both ready levels follow id_valid
    check("rx_ready", 64'(rx_ready), 64'(!before_id));
    check("mem_resp_ready", 64'(mem_resp_ready), 64'(!before_id));
    rx       = '0;
    rx.data[0] = f[1];
    rx.data[1] = f[2];
    rx.data[2] = f[3];
    rx.data[3] = f[4];
    rx.data[4] = f[5];
    rx.sop   = 1'b1;
    rx.eop   = 1'b1;
    rx.empty = 3'd3;
    rx.valid = 1'b1;
    watch_outputs();
    // Expected request, 2 cycles after beat
    if (f[6] != 0) begin
      if (req_cyc == 0) report("timeout waiting for memory request");
      else begin
        check("mem_req latency", 64'(req_cyc), 64'd2);
        check("mem_req.write", 64'(seen_req.write), 64'(f[7][0]));
        check("mem_req.req_id", 64'(seen_req.req_id), 64'(f[2][31:16]));
        check("mem_req.tag", 64'(seen_req.tag), 64'(f[2][15:8]));
        check("mem_req.addr", 64'(seen_req.addr), 64'(f[8]));
        if (f[7][0]) check("mem_req.wdata", 64'(seen_req.wdata), 64'(f[9]));
      end
    end else if (req_cyc != 0) report("unexpected memory request");
    if (f[10] != 0) begin
      if (ur_cpl_cyc == 0) report("timeout waiting for UR completion");
      else begin
        check("cpl_instant latency", 64'(ur_cpl_cyc), 64'd2);
        check("cpl_instant.sop", 64'(seen_ur_cpl.sop), 64'd1);
        check("cpl_instant.eop", 64'(seen_ur_cpl.eop), 64'd1);
        check("cpl_instant.dw0", 64'(seen_ur_cpl.data[0]), 64'h0A00_0000);
        check("cpl_instant.dw1", 64'(seen_ur_cpl.data[1]), 64'(f[11]));
        check("cpl_instant.dw2", 64'(seen_ur_cpl.data[2]), 64'(f[12]));
        check("cpl_instant.empty", 64'(seen_ur_cpl.empty), 64'd5);
      end
    end else if (ur_cpl_cyc != 0) report("unexpected UR completion");
    check("ur_posted seen", 64'(urp_cyc != 0), 64'(f[13][0]));
    check("ur_nonposted seen", 64'(urnp_cyc != 0), 64'(f[14][0]));
    // Error pulses one cycle after the start pulse
    if (urp_cyc != 0) check("ur_posted latency", 64'(urp_cyc), 64'd2);
    if (urnp_cyc != 0) check("ur_nonposted latency", 64'(urnp_cyc), 64'd2);
    if (rsp_cyc != 0) report("unexpected response completion");
    if (before_id) id_valid = 1'b1;   // Back to normal operation
  endtask

  task automatic run_resp_case(input logic [31:0] f[15]);
    int idx;
    @(negedge clk);
    check("mem_resp_ready", 64'(mem_resp_ready), 64'd1);
    mem_resp.req_id     = f[1][15:0];
    mem_resp.tag        = f[2][7:0];
    mem_resp.lower_addr = f[3][4:0];
    mem_resp.rsvd       = 3'd0;
    mem_resp.rdata      = f[4];
    mem_resp_valid      = 1'b1;
    watch_outputs();
    idx = int'(f[9]);
    if (rsp_cyc == 0) report("timeout waiting for data completion");
    else begin
      check("cpl_response latency", 64'(rsp_cyc), 64'd1);
      check("cpl_response.sop", 64'(seen_rsp.sop), 64'd1);
      check("cpl_response.eop", 64'(seen_rsp.eop), 64'd1);
      check("cpl_response.dw0", 64'(seen_rsp.data[0]), 64'(f[6]));
      check("cpl_response.dw1", 64'(seen_rsp.data[1]), 64'(f[7]));
      check("cpl_response.dw2", 64'(seen_rsp.data[2]), 64'(f[8]));
      check("cpl_response.rdata", 64'(seen_rsp.data[idx[2:0]]), 64'(f[4]));
      check("cpl_response.empty", 64'(seen_rsp.empty), 64'(f[10][2:0]));
    end
    if (req_cyc != 0 || ur_cpl_cyc != 0) report("response caused receive side output");
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] f[15];
    checks         = 0;
    errors         = 0;
    reset          = 1'b1;
    rx             = '0;
    completer_id   = COMPLETER;
    id_valid       = 1'b0;
    mem_resp       = '0;
    mem_resp_valid = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check("cpl_instant.valid after reset", 64'(cpl_instant.valid), 64'd0);
    check("cpl_response.valid after reset", 64'(cpl_response.valid), 64'd0);
    check("mem_req_valid after reset", 64'(mem_req_valid), 64'd0);
    check("ur_posted after reset", 64'(ur_posted), 64'd0);
    check("ur_nonposted after reset", 64'(ur_nonposted), 64'd0);
    repeat (2) @(negedge clk);
    id_valid = 1'b1;   // Completer ID now known
    fd = $fopen("tlp_cases.txt", "r");
    if (fd == 0) report("cannot open tlp_cases.txt");
    else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
          if (n != 15) report("malformed line in case file");
          else if (f[0] == 0) run_rx_case(f, 1'b0);
          else if (f[0] == 1) run_resp_case(f);
          else run_rx_case(f, 1'b1);
        end
      end
      $fclose(fd);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: pcie_tlp_handler.sv
// PCIe transaction-layer target, top level
// Serves single-dword memory reads and writes to a BAR region
// over a 256-bit Avalon-ST receive stream, with UR completions
// on the instant stream and read data on the response stream
`timescale 1ns/1ps

module pcie_tlp_handler import tlp_pkg::*; #(
  parameter int REGION_BITS = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  st_beat_t    rx,
  output logic        rx_ready,
  input  logic [15:0] completer_id,
  input  logic        id_valid,
  output mem_req_t    mem_req,
  output logic        mem_req_valid,
  input  mem_resp_t   mem_resp,
  input  logic        mem_resp_valid,
  output logic        mem_resp_ready,
  output st_beat_t    cpl_instant,
  output st_beat_t    cpl_response,
  output logic        ur_posted,
  output logic        ur_nonposted
);

  rx_frame_t frame;   // Current TLP from decoder

  assign mem_resp_ready = rx_ready;   // Same condition as receive

  tlp_rx_decoder i_decoder (
    .clk      (clk),
    .reset    (reset),
    .rx       (rx),
    .id_valid (id_valid),
    .rx_ready (rx_ready),
    .frame    (frame)
  );

  tlp_rx_dispatch #(
    .REGION_BITS (REGION_BITS)
  ) i_dispatch (
    .clk           (clk),
    .reset         (reset),
    .frame         (frame),
    .completer_id  (completer_id),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .cpl_instant   (cpl_instant),
    .ur_posted     (ur_posted),
    .ur_nonposted  (ur_nonposted)
  );

  read_cpl_sender i_cpl_sender (
    .clk            (clk),
    .reset          (reset),
    .mem_resp       (mem_resp),
    .mem_resp_valid (mem_resp_valid & mem_resp_ready),   // Accepted only
    .completer_id   (completer_id),
    .cpl_response   (cpl_response)
  );

endmodule

// File: read_cpl_sender.sv
// Read completion sender
// Builds a one-dword CplD from each memory agent response
// and sends it on the response stream the next cycle
`timescale 1ns/1ps

module read_cpl_sender import tlp_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  mem_resp_t   mem_resp,
  input  logic        mem_resp_valid,
  input  logic [15:0] completer_id,
  output st_beat_t    cpl_response
);

  logic qword_aligned;   // Address bit 2 clear

  assign qword_aligned = ~mem_resp.lower_addr[0];

  always_ff @(posedge clk) begin
    if (mem_resp_valid) begin
      cpl_response.data    <= '0;
      cpl_response.data[0] <= {FMT_CPLD, TYPE_CPL, 14'd0, 10'd1};  // One dword
      cpl_response.data[1] <= {completer_id, CPL_STATUS_SC, 1'b0, 12'd4};
      cpl_response.data[2] <= {mem_resp.req_id, mem_resp.tag, 1'b0,
                               mem_resp.lower_addr, 2'b00};
      // Aligned address pads the header by one dword
      if (qword_aligned) begin
        cpl_response.data[4] <= mem_resp.rdata;
        cpl_response.empty   <= 3'd3;
      end else begin
        cpl_response.data[3] <= mem_resp.rdata;
        cpl_response.empty   <= 3'd4;
      end
    end
    if (reset) begin
      cpl_response.valid <= 1'b0;
      cpl_response.sop   <= 1'b0;
      cpl_response.eop   <= 1'b0;
    end else begin
      // Single-beat TLP
      cpl_response.valid <= mem_resp_valid;
      cpl_response.sop   <= mem_resp_valid;
      cpl_response.eop   <= mem_resp_valid;
    end
  end

endmodule

// File: tlp_rx_dispatch.sv
// Receive frame dispatch
// Turns a finished request into a memory access, or into an
// Unsupported-Request completion on the instant stream, and
// raises the UR error pulses for the hard IP
`timescale 1ns/1ps

module tlp_rx_dispatch import tlp_pkg::*; #(
  parameter int REGION_BITS = 16   // BAR region offset bits, at least 7
) (
  input  logic        clk,
  input  logic        reset,
  input  rx_frame_t   frame,
  input  logic [15:0] completer_id,
  output mem_req_t    mem_req,
  output logic        mem_req_valid,
  output st_beat_t    cpl_instant,
  output logic        ur_posted,
  output logic        ur_nonposted
);

  localparam logic [31:0] REGION_MASK = 32'((64'd1 << REGION_BITS) - 64'd1);

  logic [31:0] masked_addr;
  logic        do_access;     // Supported memory request finished
  logic        do_ur_cpl;     // Unsupported non-posted request finished

  assign masked_addr = frame.addr & REGION_MASK;
  assign do_access   = frame.is_end & ~frame.unsupported &
                       (frame.kind == MRD || frame.kind == MWR);
  assign do_ur_cpl   = frame.is_end & frame.unsupported & frame.is_npr;

  // Memory access request
  always_ff @(posedge clk) begin
    if (do_access) begin
      mem_req.write  <= (frame.kind == MWR);
      mem_req.req_id <= frame.req_id;
      mem_req.tag    <= frame.tag;
      mem_req.addr   <= masked_addr[31:2];
      mem_req.wdata  <= frame.data;   // Ignored on reads
    end
    if (reset)
      mem_req_valid <= 1'b0;
    else
      mem_req_valid <= do_access;
  end

  // Header-only UR completion, sink has zero ready latency
  always_ff @(posedge clk) begin
    if (do_ur_cpl) begin
      cpl_instant.data    <= '0;
      cpl_instant.data[0] <= {FMT_CPL, TYPE_CPL, 24'd0};   // Length 0
      cpl_instant.data[1] <= {completer_id, CPL_STATUS_UR, 1'b0, frame.byte_count};
      // Lower address echoed from request
      cpl_instant.data[2] <= {frame.req_id, frame.tag, 1'b0, frame.addr[6:0]};
      cpl_instant.empty   <= 3'd5;   // Three header dwords
    end
    if (reset) begin
      cpl_instant.valid <= 1'b0;
      cpl_instant.sop   <= 1'b0;
      cpl_instant.eop   <= 1'b0;
    end else begin
      cpl_instant.valid <= do_ur_cpl;
      cpl_instant.sop   <= do_ur_cpl;
      cpl_instant.eop   <= do_ur_cpl;
    end
  end

  // cpl_err UR pulses, once per TLP at its start
  always_ff @(posedge clk) begin
    if (reset) begin
      ur_posted    <= 1'b0;
      ur_nonposted <= 1'b0;
    end else begin
      ur_posted    <= frame.is_start & frame.unsupported & frame.is_pr;
      ur_nonposted <= frame.is_start & frame.unsupported & frame.is_npr;
    end
  end

endmodule

// File: tlp_rx_decoder.sv
// Receive TLP decoder
// Captures the header fields of each accepted start beat,
// classifies the request as posted or non-posted and flags
// requests this target does not serve
`timescale 1ns/1ps

module tlp_rx_decoder import tlp_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  st_beat_t  rx,
  input  logic      id_valid,
  output logic      rx_ready,
  output rx_frame_t frame
);

  logic        accept;       // Beat taken this cycle
  logic [2:0]  fmt;
  logic [4:0]  raw_type;
  logic [9:0]  length;
  logic        is_4dw;
  tlp_kind_t   kind;
  logic [11:0] byte_count;
  logic        is_npr;
  logic        is_pr;
  logic        unsupported;

  // Ready as soon as the completer ID is known
  assign rx_ready = id_valid;
  assign accept   = rx.valid & rx_ready;

  // Header dword 0 fields
  assign fmt      = rx.data[0][31:29];
  assign raw_type = rx.data[0][28:24];
  assign length   = rx.data[0][9:0];
  assign is_4dw   = fmt[0];

  tlp_byte_count i_byte_count (
    .length     (length),
    .first_be   (rx.data[1][3:0]),
    .last_be    (rx.data[1][7:4]),
    .byte_count (byte_count)
  );

  always_comb begin
    case ({fmt[1], raw_type})
      6'b000000: kind = MRD;
      6'b000001: kind = MRDLK;
      6'b100000: kind = MWR;
      6'b001010: kind = CPL;
      6'b101010: kind = CPLD;
      default:   kind = UNKNOWN;
    endcase
  end

  // Non-posted requests need a completion back
  always_comb begin
    is_npr = 1'b0;
    is_pr  = 1'b0;
    casez ({fmt[1], raw_type})
      6'b00000?: is_npr = 1'b1;  // MRd, MRdLk
      6'b?00010: is_npr = 1'b1;  // IORd, IOWr
      6'b1011??: is_npr = 1'b1;  // AtomicOp
      6'b100000: is_pr  = 1'b1;  // MWr
      6'b?10???: is_pr  = 1'b1;  // Msg, MsgD
      default:   ;
    endcase
  end

  // Only single-dword 32-bit memory accesses are served
  always_comb begin
    unsupported = 1'b0;
    if (kind == UNKNOWN)
      unsupported = 1'b1;
    else if (kind == CPL || kind == MRDLK)
      unsupported = 1'b1;
    else if (is_4dw)
      unsupported = 1'b1;   // 64-bit addressing
    else if (kind == MRD || kind == MWR) begin
      if (length != 10'd1)
        unsupported = 1'b1;
      else if (byte_count != 12'd4)
        unsupported = 1'b1; // Partial dword
    end
  end

  always_ff @(posedge clk) begin
    if (accept && rx.sop) begin
      frame.kind       <= kind;
      frame.req_id     <= rx.data[1][31:16];
      frame.tag        <= rx.data[1][15:8];
      frame.first_be   <= rx.data[1][3:0];
      frame.addr       <= {rx.data[2][31:2], 2'b00};
      frame.byte_count <= byte_count;
      // Payload is qword aligned in the beat: dword 4 unless address bit 2 set
      frame.data       <= rx.data[2][2] ? rx.data[3] : rx.data[4];
    end
    if (reset) begin
      frame.is_npr      <= 1'b0;
      frame.is_pr       <= 1'b0;
      frame.unsupported <= 1'b0;
      frame.is_start    <= 1'b0;
      frame.is_end      <= 1'b0;
    end else begin
      if (accept && rx.sop) begin
        frame.is_npr      <= is_npr;
        frame.is_pr       <= is_pr;
        frame.unsupported <= unsupported;
      end
      frame.is_start <= accept & rx.sop;
      frame.is_end   <= accept & rx.eop;
    end
  end

endmodule

// File: tlp_byte_count.sv
// TLP byte count calculation
// Derives the byte count of a memory request from its length
// and first/last byte enables, per the PCIe byte count table
`timescale 1ns/1ps

module tlp_byte_count (
  input  logic [9:0]  length,
  input  logic [3:0]  first_be,
  input  logic [3:0]  last_be,
  output logic [11:0] byte_count
);

  logic [1:0] first_skip;   // Disabled bytes below the first enabled one
  logic [1:0] last_skip;    // Disabled bytes above the last enabled one

  always_comb begin
    casez (first_be)
      4'b???1: first_skip = 2'd0;
      4'b??10: first_skip = 2'd1;
      4'b?100: first_skip = 2'd2;
      default: first_skip = 2'd3;
    endcase
    casez (last_be)
      4'b1???: last_skip = 2'd0;
      4'b01??: last_skip = 2'd1;
      4'b001?: last_skip = 2'd2;
      default: last_skip = 2'd3;
    endcase
  end

  always_comb begin
    if (last_be == 4'b0000) begin
      // Single dword, span from lowest to highest enabled byte
      casez (first_be)
        4'b1??1:                   byte_count = 12'd4;
        4'b01?1, 4'b1?10:          byte_count = 12'd3;
        4'b0011, 4'b0110, 4'b1100: byte_count = 12'd2;
        default:                   byte_count = 12'd1;  // One byte or none
      endcase
    end else if (first_be == 4'b0000) begin
      byte_count = 12'd0;   // Invalid for multi-dword
    end else begin
      byte_count = {length, 2'b00} - {10'd0, first_skip} - {10'd0, last_skip};
    end
  end

endmodule

// File: tlp_pkg.sv
// Shared TLP definitions for the PCIe BAR target
// Field widths, format and type codes, completion status codes
// and the structs passed between the receive, dispatch and
// completion blocks
package tlp_pkg;

  localparam int DW_PER_BEAT = 8;       // 256-bit beat

  // Completion header codes
  localparam logic [2:0] FMT_CPL  = 3'b000;  // 3DW, no data
  localparam logic [2:0] FMT_CPLD = 3'b010;  // 3DW, with data
  localparam logic [4:0] TYPE_CPL = 5'b01010;

  // Completion status
  localparam logic [2:0] CPL_STATUS_SC = 3'd0;  // Successful
  localparam logic [2:0] CPL_STATUS_UR = 3'd1;  // Unsupported Request

  typedef enum logic [2:0] {
    MRD,
    MRDLK,
    MWR,
    CPL,
    CPLD,
    UNKNOWN
  } tlp_kind_t;

  // One beat as dwords, dword 0 in the low bits
  typedef logic [DW_PER_BEAT-1:0][31:0] beat_t;

  // Avalon-ST beat, empty counts unused dwords at the top
  typedef struct packed {
    beat_t      data;
    logic       sop;
    logic       eop;
    logic [2:0] empty;
    logic       valid;
  } st_beat_t;

  // Decoded view of the TLP in flight
  typedef struct packed {
    tlp_kind_t   kind;
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [31:0] addr;         // Byte address, bits 1:0 zero
    logic [3:0]  first_be;
    logic [31:0] data;         // Single write dword
    logic [11:0] byte_count;
    logic        is_npr;       // Needs a completion
    logic        is_pr;
    logic        unsupported;
    logic        is_start;     // One cycle after start beat
    logic        is_end;       // One cycle after end beat
  } rx_frame_t;

  // Request to the memory agent
  typedef struct packed {
    logic        write;
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [29:0] addr;         // Dword address within region
    logic [31:0] wdata;
  } mem_req_t;

  // Memory agent answer, 64 bits
  typedef struct packed {
    logic [31:0] rdata;
    logic [2:0]  rsvd;
    logic [4:0]  lower_addr;   // Address bits 6:2
    logic [7:0]  tag;
    logic [15:0] req_id;
  } mem_resp_t;

endpackage
